//--- Makefile
# Verilator lint and simulation of the pipeline back end

VERILATOR   ?= verilator
TOP         ?= tb_frv_pipeline_back
DUT_TOP     ?= frv_pipeline_back
FILELIST    ?= project.f
BUILD_DIR   ?= build
LOG         ?= sim.log
LINT_FLAGS  ?= --lint-only --timing --assert
BUILD_FLAGS ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST)) dv/frv_testdata.txt
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/frv_pkg.sv
`default_nettype none
// --------------------
// Shared widths, micro-op codes and the stage
// and Wishbone structs of the pipeline back end
// --------------------
package frv_pkg;

  localparam int XLEN   = 32;              // Data path width
  localparam int REG_AW = 5;               // GPR address width
  localparam int UOP_W  = 5;               // Micro-op code width
  localparam int SEL_W  = XLEN / 8;        // Wishbone byte selects

  // --------------------
  // Micro-op codes from the decoder
  typedef enum logic [UOP_W-1:0] {
    UOP_ADD  = 5'd0,
    UOP_SUB  = 5'd1,
    UOP_AND  = 5'd2,
    UOP_OR   = 5'd3,
    UOP_XOR  = 5'd4,
    UOP_SLT  = 5'd5,
    UOP_SLTU = 5'd6,
    UOP_SLL  = 5'd7,
    UOP_SRL  = 5'd8,
    UOP_SRA  = 5'd9,
    UOP_LUI  = 5'd10,                      // Immediate passes through
    UOP_LW   = 5'd11,                      // Word load
    UOP_SW   = 5'd12                       // Word store
  } frv_uop_e;

  // --------------------
  // Stage payloads
  typedef struct packed {
    logic [REG_AW-1:0] rd;                 // Destination register
    logic [REG_AW-1:0] rs1;                // Source register 1
    logic [REG_AW-1:0] rs2;                // Source register 2
    logic [XLEN-1:0]   imm;                // Decoded immediate
    frv_uop_e          uop;                // Operation
    logic              use_imm;            // Operand B from imm
  } frv_decoded_t;

  typedef struct packed {
    logic [REG_AW-1:0] rd;                 // Zero for stores
    logic [XLEN-1:0]   opr_a;              // Operand A
    logic [XLEN-1:0]   opr_b;              // Operand B
    logic [XLEN-1:0]   opr_c;              // Store data
    frv_uop_e          uop;
  } frv_execute_t;

  typedef struct packed {
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   wdata;              // Value to retire
    logic              wen;                // GPR write wanted
    logic              fault;              // Bus error seen
  } frv_result_t;

  // --------------------
  // Wishbone classic data bus
  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [SEL_W-1:0] sel;
    logic [XLEN-1:0]  adr;
    logic [XLEN-1:0]  dat;                 // Write data
  } frv_wb_req_t;

  typedef struct packed {
    logic            ack;
    logic            err;
    logic [XLEN-1:0] dat;                  // Read data
  } frv_wb_rsp_t;

endpackage
`default_nettype wire

//--- design/frv_pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none
// --------------------
// One-entry stage register with valid/busy
// handshake and flush
// --------------------
module frv_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     g_clk,
  input  logic     rst,
  input  logic     flush,     // Empty the stage
  input  logic     i_valid,   // Upstream offers a payload
  output logic     i_busy,    // Upstream must hold
  input  payload_t i_data,
  output logic     o_valid,   // Payload available downstream
  input  logic     o_busy,    // Downstream holding us
  output payload_t o_data
);

  logic     full_q;           // Entry occupied
  payload_t data_q;           // Held payload
  logic     take;
  logic     leave;

  assign take   = i_valid && !i_busy;
  assign leave  = full_q && !o_busy;
  assign i_busy = full_q && o_busy;   // Free or draining means ready

  always_ff @(posedge g_clk) begin
    if (rst || flush) begin
      full_q <= 1'b0;
    end else if (take) begin
      full_q <= 1'b1;                 // Refill, also when draining
    end else if (leave) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge g_clk) begin
    if (take) begin
      data_q <= i_data;
    end
  end

  assign o_valid = full_q;
  assign o_data  = data_q;

  // Stalled payload must not change under the consumer
  a_hold_stable: assert property (@(posedge g_clk) disable iff (rst)
    o_valid && o_busy |=> $stable(o_data));

endmodule
`default_nettype wire

//--- design/frv_pipeline_back.sv
`timescale 1ns/1ps
`default_nettype none
// --------------------
// Pipeline back end. Dispatch, execute stage
// register, execute and writeback
// --------------------
module frv_pipeline_back (
  input  logic                  g_clk,       // Core clock
  input  logic                  rst,         // Sync reset, active high
  input  logic                  flush,       // Drop the op in s3
  input  logic                  s2_p_valid,  // Front end has an op
  input  frv_pkg::frv_decoded_t s2_instr,    // Decoded op
  output logic                  s2_p_busy,   // Back end cannot take it
  output frv_pkg::frv_wb_req_t  dmem_req,    // Data bus master side
  input  frv_pkg::frv_wb_rsp_t  dmem_rsp,    // Data bus slave side
  output logic                  mem_fault    // One pulse per bus error
);
  import frv_pkg::*;

  // --------------------
  // Inter-stage wiring
  logic              s3_p_valid;   // Dispatch output valid
  logic              s3_p_busy;    // Stage register full
  frv_execute_t      s3_data;      // Gathered operands
  logic              ex_valid;     // Op waiting in execute
  logic              ex_busy;      // Execute holding the op
  frv_execute_t      ex_data;
  logic              res_valid;    // Execute result strobe
  frv_result_t       res_data;
  logic              gpr_wen;      // Writeback port, also forwarding
  logic [REG_AW-1:0] gpr_rd;
  logic [XLEN-1:0]   gpr_wdata;

  frv_pipeline_dispatch u_dispatch (
    .g_clk      (g_clk),
    .rst        (rst),
    .flush      (flush),
    .s2_p_valid (s2_p_valid),
    .s2_instr   (s2_instr),
    .s2_p_busy  (s2_p_busy),
    .s3_p_valid (s3_p_valid),
    .s3_data    (s3_data),
    .s3_p_busy  (s3_p_busy),
    .ex_rd      (ex_data.rd),
    .ex_valid   (ex_valid),
    .gpr_wen    (gpr_wen),
    .gpr_rd     (gpr_rd),
    .gpr_wdata  (gpr_wdata)
  );

  frv_pipe_reg #(.payload_t(frv_execute_t)) u_s3_reg (
    .g_clk   (g_clk),
    .rst     (rst),
    .flush   (flush),
    .i_valid (s3_p_valid),
    .i_busy  (s3_p_busy),
    .i_data  (s3_data),
    .o_valid (ex_valid),
    .o_busy  (ex_busy),
    .o_data  (ex_data)
  );

  frv_pipeline_execute u_execute (
    .g_clk     (g_clk),
    .rst       (rst),
    .ex_valid  (ex_valid),
    .ex_data   (ex_data),
    .ex_busy   (ex_busy),
    .res_valid (res_valid),
    .res_data  (res_data),
    .dmem_req  (dmem_req),
    .dmem_rsp  (dmem_rsp)
  );

  frv_pipeline_writeback u_writeback (
    .g_clk     (g_clk),
    .rst       (rst),
    .res_valid (res_valid),
    .res_data  (res_data),
    .gpr_wen   (gpr_wen),
    .gpr_rd    (gpr_rd),
    .gpr_wdata (gpr_wdata),
    .mem_fault (mem_fault)
  );

endmodule
`default_nettype wire

//--- design/frv_pipeline_writeback.sv
`timescale 1ns/1ps
`default_nettype none
// --------------------
// Writeback stage. Drives the GPR write port
// and the bus fault pulse
// --------------------
module frv_pipeline_writeback (
  input  logic                       g_clk,
  input  logic                       rst,
  input  logic                       res_valid,  // Execute result strobe
  input  frv_pkg::frv_result_t       res_data,
  output logic                       gpr_wen,    // Also s4 hazard info
  output logic [frv_pkg::REG_AW-1:0] gpr_rd,
  output logic [frv_pkg::XLEN-1:0]   gpr_wdata,
  output logic                       mem_fault   // One cycle per error
);
  import frv_pkg::*;

  logic              wen_q;
  logic              fault_q;
  logic [REG_AW-1:0] rd_q;      // Retiring destination
  logic [XLEN-1:0]   wdata_q;

  always_ff @(posedge g_clk) begin
    if (rst) begin
      wen_q   <= 1'b0;
      fault_q <= 1'b0;
    end else begin
      wen_q   <= res_valid && res_data.wen;
      fault_q <= res_valid && res_data.fault;   // Pulse, no hold
    end
  end

  always_ff @(posedge g_clk) begin
    if (res_valid) begin
      rd_q    <= res_data.rd;
      wdata_q <= res_data.wdata;
    end
  end

  assign gpr_wen   = wen_q;
  assign gpr_rd    = rd_q;
  assign gpr_wdata = wdata_q;
  assign mem_fault = fault_q;

endmodule
`default_nettype wire

//--- dispatch/frv_gprs.sv
`timescale 1ns/1ps
`default_nettype none
// --------------------
// General register file, 32 x 32, two read
// ports, x0 reads as zero
// --------------------
module frv_gprs (
  input  logic                       g_clk,
  input  logic                       rst,
  input  logic [frv_pkg::REG_AW-1:0] rs1,     // Read port 1
  input  logic [frv_pkg::REG_AW-1:0] rs2,     // Read port 2
  output logic [frv_pkg::XLEN-1:0]   rdata1,
  output logic [frv_pkg::XLEN-1:0]   rdata2,
  input  logic                       wen,     // Write port
  input  logic [frv_pkg::REG_AW-1:0] rd,
  input  logic [frv_pkg::XLEN-1:0]   wdata
);
  import frv_pkg::*;

  logic [XLEN-1:0] regs_q [1:31];   // No storage for x0

  always_ff @(posedge g_clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wen && |rd) begin  // x0 writes ignored
      regs_q[rd] <= wdata;
    end
  end

  assign rdata1 = |rs1 ? regs_q[rs1] : '0;
  assign rdata2 = |rs2 ? regs_q[rs2] : '0;

endmodule
`default_nettype wire

//--- dispatch/frv_pipeline_dispatch.sv
`timescale 1ns/1ps
`default_nettype none
// --------------------
// Dispatch stage. Reads the GPRs, forwards the
// writeback value and stalls on RAW hazards
// --------------------
module frv_pipeline_dispatch (
  input  logic                          g_clk,
  input  logic                          rst,
  input  logic                          flush,       // Drop this op
  input  logic                          s2_p_valid,  // Decoded op offered
  input  frv_pkg::frv_decoded_t         s2_instr,
  output logic                          s2_p_busy,   // Hold the front end
  output logic                          s3_p_valid,  // Operands ready
  output frv_pkg::frv_execute_t         s3_data,
  input  logic                          s3_p_busy,   // Stage register full
  input  logic [frv_pkg::REG_AW-1:0]    ex_rd,       // Dest of op in execute
  input  logic                          ex_valid,
  input  logic                          gpr_wen,     // Writeback port
  input  logic [frv_pkg::REG_AW-1:0]    gpr_rd,
  input  logic [frv_pkg::XLEN-1:0]      gpr_wdata
);
  import frv_pkg::*;

  logic [XLEN-1:0]   rf_rdata1;      // Raw file reads
  logic [XLEN-1:0]   rf_rdata2;
  logic [XLEN-1:0]   rs1_val;        // After forwarding
  logic [XLEN-1:0]   rs2_val;
  logic              prev_valid_q;   // Op now in execute result reg
  logic [REG_AW-1:0] prev_rd_q;
  logic              is_store;
  logic              use_rs1;
  logic              use_rs2;
  logic              raw_rs1;
  logic              raw_rs2;
  logic              hazard;

  frv_gprs u_gprs (
    .g_clk  (g_clk),
    .rst    (rst),
    .rs1    (s2_instr.rs1),
    .rs2    (s2_instr.rs2),
    .rdata1 (rf_rdata1),
    .rdata2 (rf_rdata2),
    .wen    (gpr_wen),
    .rd     (gpr_rd),
    .wdata  (gpr_wdata)
  );

  // --------------------
  // Forwarding from the write in this cycle
  assign rs1_val = (gpr_wen && gpr_rd == s2_instr.rs1 && |s2_instr.rs1) ?
                   gpr_wdata : rf_rdata1;
  assign rs2_val = (gpr_wen && gpr_rd == s2_instr.rs2 && |s2_instr.rs2) ?
                   gpr_wdata : rf_rdata2;

  // Whatever sat in the stage register last cycle may now be
  // in the execute result register, one step before writeback
  always_ff @(posedge g_clk) begin
    if (rst) begin
      prev_valid_q <= 1'b0;
      prev_rd_q    <= '0;
    end else begin
      prev_valid_q <= ex_valid;
      prev_rd_q    <= ex_rd;
    end
  end

  // --------------------
  // RAW hazard detection
  assign is_store = s2_instr.uop == UOP_SW;
  assign use_rs1  = s2_instr.uop != UOP_LUI;
  assign use_rs2  = !s2_instr.use_imm || is_store;   // Stores read rs2 as data

  assign raw_rs1 = use_rs1 && |s2_instr.rs1 &&
                   ((ex_valid && ex_rd == s2_instr.rs1) ||
                    (prev_valid_q && prev_rd_q == s2_instr.rs1));
  assign raw_rs2 = use_rs2 && |s2_instr.rs2 &&
                   ((ex_valid && ex_rd == s2_instr.rs2) ||
                    (prev_valid_q && prev_rd_q == s2_instr.rs2));

  assign hazard     = s2_p_valid && (raw_rs1 || raw_rs2);
  assign s2_p_busy  = hazard || s3_p_busy;
  assign s3_p_valid = s2_p_valid && !hazard && !flush;

  always_comb begin
    s3_data.rd    = is_store ? '0 : s2_instr.rd;     // Stores retire nothing
    s3_data.opr_a = rs1_val;
    s3_data.opr_b = s2_instr.use_imm ? s2_instr.imm : rs2_val;
    s3_data.opr_c = is_store ? rs2_val : '0;         // Store data
    s3_data.uop   = s2_instr.uop;
  end

endmodule
`default_nettype wire

//--- dv/frv_testdata.txt
// kind 1 op:    1_rd_rs1_rs2_imm(8)_uop_useimm   uop 00 add .. 0a lui 0b lw 0c sw
// kind 2 store: 2_0_adr_dat (expected)           kind 3 err load: 3_0_adr_00000000
1_01_00_00_f0f00000_0a_1  // lui x1
1_01_01_00_000000f0_00_1  // x1 = f0f000f0, back to back
1_02_00_00_00000024_00_1  // x2 = 0x24, shift amount 4
1_03_01_02_00000000_00_0  // add
1_00_00_03_00000100_0c_1
2_0_00000100_f0f00114
1_04_01_02_00000000_01_0  // sub
1_00_00_04_00000104_0c_1
2_0_00000104_f0f000cc
1_05_01_02_00000000_02_0  // and
1_00_00_05_00000108_0c_1
2_0_00000108_00000020
1_06_01_02_00000000_03_0  // or
1_00_00_06_0000010c_0c_1
2_0_0000010c_f0f000f4
1_07_01_02_00000000_04_0  // xor
1_00_00_07_00000110_0c_1
2_0_00000110_f0f000d4
1_08_01_02_00000000_05_0  // slt, negative vs positive
1_00_00_08_00000114_0c_1
2_0_00000114_00000001
1_09_01_02_00000000_06_0  // sltu
1_00_00_09_00000118_0c_1
2_0_00000118_00000000
1_0a_01_02_00000000_07_0  // sll
1_00_00_0a_0000011c_0c_1
2_0_0000011c_0f000f00
1_0b_01_02_00000000_08_0  // srl
1_00_00_0b_00000120_0c_1
2_0_00000120_0f0f000f
1_0c_01_02_00000000_09_0  // sra
1_00_00_0c_00000124_0c_1
2_0_00000124_ff0f000f
1_0d_01_02_00000000_00_0  // dependent chain through x13
1_0d_0d_02_00000000_01_0
1_00_00_0d_00000128_0c_1
2_0_00000128_f0f000f0
1_00_00_01_00000200_0c_1  // store, load back, store again
2_0_00000200_f0f000f0
1_0f_00_00_00000200_0b_1
1_00_00_0f_00000204_0c_1
2_0_00000204_f0f000f0
1_10_00_00_00000055_00_1  // x16 = 0x55, then a faulting load
1_10_00_00_00000300_0b_1
3_0_00000300_00000000
1_00_00_10_00000304_0c_1
2_0_00000304_00000055
1_00_01_02_00000000_00_0  // write to x0 is dropped
1_00_00_00_00000308_0c_1
2_0_00000308_00000000

//--- dv/tb_frv_pipeline_back.sv
`timescale 1ns/1ps
`default_nettype none
// --------------------
// Testbench for the pipeline back end. Feeds the
// micro-op stream from the data file, models the
// Wishbone memory with random wait states
// --------------------
module tb_frv_pipeline_back;
  import frv_pkg::*;

  localparam int CLK_HALF  = 20;           // 40 ns period
  localparam int DRIVE_DLY = 2;            // Inputs change after the edge
  localparam int TIMEOUT   = 200;          // Cycles per wait loop
  localparam int NREC      = 64;

  logic         g_clk;
  logic         rst;
  logic         flush;
  logic         s2_p_valid;
  logic         s2_p_busy;
  logic         mem_fault;
  frv_decoded_t s2_instr;
  frv_wb_req_t  dmem_req;
  frv_wb_rsp_t  dmem_rsp;

  logic [71:0]  recs [0:NREC-1];           // Raw file records
  frv_decoded_t prog_q [$];                // Micro-op stream
  logic [63:0]  store_q [$];               // {adr, dat} in program order
  logic [31:0]  err_q [$];                 // Loads answered with err
  logic [31:0]  mem [logic [31:0]];        // Bus memory
  logic [31:0]  lfsr_q;
  int           errors;
  int           stores_seen;
  int           faults_seen;
  logic         busy_seen;                 // Stall seen under a waiting bus
  logic         fault_d;                   // mem_fault one sample ago

  frv_pipeline_back DUT (
    .g_clk      (g_clk),
    .rst        (rst),
    .flush      (flush),
    .s2_p_valid (s2_p_valid),
    .s2_instr   (s2_instr),
    .s2_p_busy  (s2_p_busy),
    .dmem_req   (dmem_req),
    .dmem_rsp   (dmem_rsp),
    .mem_fault  (mem_fault)
  );

  initial begin
    g_clk = 1'b0;
    forever #CLK_HALF g_clk = ~g_clk;
  end

  // --------------------
  // Helpers
  task automatic check_word(input string what, input logic [31:0] got,
                            input logic [31:0] want);
    assert (got === want) else begin
      errors++;
      $display("error %0t: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic finish_run(input logic timed_out);
    $display("errors %0d, stores %0d, faults %0d", errors, stores_seen, faults_seen);
    if (errors == 0 && !timed_out) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timed out while waiting for %s", what);
    finish_run(1'b1);
  endtask

  // Galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic lfsr_bit();
    logic b;
    b      = lfsr_q[0];
    lfsr_q = lfsr_next(lfsr_q);
    return b;
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return {a[15:0], a[31:16]} ^ 32'hc3a5_5a3c;   // Unwritten locations
  endfunction

  function automatic logic is_err_addr(input logic [31:0] a);
    foreach (err_q[i]) begin
      if (err_q[i] == a) return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic load_records();
    logic [3:0]   kind;
    frv_decoded_t u;
    $readmemh("dv/frv_testdata.txt", recs);
    for (int i = 0; i < NREC; i++) begin
      kind = recs[i][71:68];
      if (kind == 4'h1) begin                     // Micro-op
        u.rd      = recs[i][64:60];
        u.rs1     = recs[i][56:52];
        u.rs2     = recs[i][48:44];
        u.imm     = recs[i][43:12];
        u.uop     = frv_uop_e'(recs[i][8:4]);
        u.use_imm = recs[i][0];
        prog_q.push_back(u);
      end else if (kind == 4'h2) begin            // Expected store
        store_q.push_back(recs[i][63:0]);
      end else if (kind == 4'h3) begin            // Error address
        err_q.push_back(recs[i][63:32]);
      end else begin
        break;                                    // End of records
      end
    end
    assert (prog_q.size() > 0) else begin
      errors++;
      $display("the micro-op file held no instructions");
    end
  endtask

  // Hold the op until dispatch takes it
  task automatic send_uop(input frv_decoded_t u, output logic taken);
    int waits;
    s2_instr   = u;
    s2_p_valid = 1'b1;
    waits      = 0;
    @(negedge g_clk);
    while (s2_p_busy && waits < TIMEOUT) begin
      @(negedge g_clk);
      waits++;
    end
    taken = waits < TIMEOUT;
    if (taken) begin
      @(posedge g_clk);                           // Transfer edge
      #DRIVE_DLY;
      s2_p_valid = 1'b0;
    end
  endtask

  // --------------------
  // Wishbone memory model
  task automatic check_request(input frv_wb_req_t snap);
    assert (dmem_req === snap) else begin
      errors++;
      $display("error %0t: bus request changed before the response", $time);
    end
  endtask

  task automatic serve_access();
    frv_wb_req_t snap;
    int          waits;
    logic [63:0] want;
    snap  = dmem_req;
    waits = 0;
    if (lfsr_bit()) waits += 2;
    if (lfsr_bit()) waits += 1;
    assert (snap.stb && snap.sel == 4'hf) else begin
      errors++;
      $display("error %0t: cyc without stb or partial sel", $time);
    end
    repeat (waits) begin
      @(posedge g_clk);
      #DRIVE_DLY;
      check_request(snap);
    end
    if (snap.we) begin
      stores_seen++;
      mem[snap.adr] = snap.dat;
      assert (store_q.size() > 0) else begin
        errors++;
        $display("error %0t: store to %h not in the expected list", $time, snap.adr);
      end
      if (store_q.size() > 0) begin
        want = store_q.pop_front();
        check_word("store address", snap.adr, want[63:32]);
        check_word("store data", snap.dat, want[31:0]);
      end
      dmem_rsp.ack = 1'b1;
    end else if (is_err_addr(snap.adr)) begin
      dmem_rsp.err = 1'b1;                        // Marked load
    end else begin
      dmem_rsp.ack = 1'b1;
      dmem_rsp.dat = mem.exists(snap.adr) ? mem[snap.adr] : fill_word(snap.adr);
    end
    @(posedge g_clk);                             // DUT samples the response
    #DRIVE_DLY;
    dmem_rsp = '0;
    assert (!dmem_req.cyc && !dmem_req.stb) else begin
      errors++;
      $display("error %0t: cyc or stb still high after the response", $time);
    end
  endtask

  initial begin
    forever begin
      @(posedge g_clk);
      #DRIVE_DLY;
      if (!rst && dmem_req.cyc) serve_access();
    end
  end

  // Fault pulses and back-pressure
  always @(negedge g_clk) begin
    if (!rst) begin
      if (dmem_req.cyc && !dmem_rsp.ack && !dmem_rsp.err) begin
        if (s2_p_busy) busy_seen = 1'b1;          // Waiting bus fills the pipe
        assert (s2_p_busy) else begin
          errors++;
          $display("error %0t: s2_p_busy low while the bus waits", $time);
        end
      end
      if (mem_fault) faults_seen++;
      assert (!(mem_fault && fault_d)) else begin
        errors++;
        $display("error %0t: mem_fault high for more than one cycle", $time);
      end
      fault_d = mem_fault;
    end
  end

  // --------------------
  // Main sequence
  initial begin
    int   waits;
    logic taken;
    $timeformat(-9, 0, " ns", 0);
    rst         = 1'b1;
    flush       = 1'b0;
    s2_p_valid  = 1'b0;
    s2_instr    = '0;
    dmem_rsp    = '0;
    lfsr_q      = 32'h3a51_3317;
    errors      = 0;
    stores_seen = 0;
    faults_seen = 0;
    busy_seen   = 1'b0;
    fault_d     = 1'b0;
    load_records();
    repeat (2) @(posedge g_clk);
    #DRIVE_DLY;
    rst = 1'b0;
    @(negedge g_clk);
    assert (!s2_p_busy && !dmem_req.cyc && !dmem_req.stb && !mem_fault) else begin
      errors++;
      $display("error %0t: outputs not low after reset", $time);
    end
    @(posedge g_clk);
    #DRIVE_DLY;
    taken = 1'b1;
    while (prog_q.size() > 0 && taken) begin
      send_uop(prog_q.pop_front(), taken);
    end
    waits = 0;
    while (taken && (store_q.size() > 0 || dmem_req.cyc) && waits < TIMEOUT) begin
      @(negedge g_clk);                           // Last access fully answered
      waits++;
    end
    if (!taken) begin
      stop_on_timeout("dispatch to accept a micro-op");
    end else if (waits >= TIMEOUT) begin
      stop_on_timeout("the remaining stores");
    end else begin
      assert (faults_seen == err_q.size()) else begin
        errors++;
        $display("error %0t: %0d fault pulses, expected %0d", $time, faults_seen,
                 err_q.size());
      end
      assert (busy_seen) else begin
        errors++;
        $display("s2_p_busy never rose while the bus was waiting");
      end
      finish_run(1'b0);
    end
  end

endmodule
`default_nettype wire

//--- execute/frv_pipeline_execute.sv
`timescale 1ns/1ps
`default_nettype none
// --------------------
// Execute stage. ALU plus a Wishbone classic
// master for word loads and stores
// --------------------
module frv_pipeline_execute (
  input  logic                  g_clk,
  input  logic                  rst,
  input  logic                  ex_valid,   // Stage register holds an op
  input  frv_pkg::frv_execute_t ex_data,
  output logic                  ex_busy,    // Keep the op in place
  output logic                  res_valid,  // One pulse per retired op
  output frv_pkg::frv_result_t  res_data,
  output frv_pkg::frv_wb_req_t  dmem_req,
  input  frv_pkg::frv_wb_rsp_t  dmem_rsp
);
  import frv_pkg::*;

  typedef enum logic {BUS_IDLE, BUS_ACCESS} bus_state_e;

  bus_state_e      state_q;       // Bus sequencer
  logic            cyc_q;         // Drives cyc and stb
  logic            we_q;
  logic [XLEN-1:0] adr_q;
  logic [XLEN-1:0] dat_q;
  logic            own_q;         // Issuing op not flushed yet
  logic            res_valid_q;
  frv_result_t     res_q;
  logic [XLEN-1:0] opr_a;
  logic [XLEN-1:0] opr_b;
  logic [XLEN-1:0] alu_out;
  logic            is_mem;
  logic            bus_rsp;       // ack or err
  logic            bus_done;
  logic            mine;          // Response belongs to current op
  logic            alu_fire;
  logic            mem_start;

  assign opr_a = ex_data.opr_a;
  assign opr_b = ex_data.opr_b;

  // --------------------
  // ALU
  always_comb begin
    case (ex_data.uop)
      UOP_ADD, UOP_LW, UOP_SW: alu_out = opr_a + opr_b;   // Also the address
      UOP_SUB:  alu_out = opr_a - opr_b;
      UOP_AND:  alu_out = opr_a & opr_b;
      UOP_OR:   alu_out = opr_a | opr_b;
      UOP_XOR:  alu_out = opr_a ^ opr_b;
      UOP_SLT:  alu_out = {{(XLEN-1){1'b0}}, $signed(opr_a) < $signed(opr_b)};
      UOP_SLTU: alu_out = {{(XLEN-1){1'b0}}, opr_a < opr_b};
      UOP_SLL:  alu_out = opr_a << opr_b[4:0];
      UOP_SRL:  alu_out = opr_a >> opr_b[4:0];
      UOP_SRA:  alu_out = $unsigned($signed(opr_a) >>> opr_b[4:0]);
      UOP_LUI:  alu_out = opr_b;                          // Immediate as is
      default:  alu_out = '0;
    endcase
  end

  // --------------------
  // Bus sequencer, one access outstanding
  assign is_mem    = ex_data.uop == UOP_LW || ex_data.uop == UOP_SW;
  assign bus_rsp   = dmem_rsp.ack || dmem_rsp.err;
  assign bus_done  = state_q == BUS_ACCESS && bus_rsp;
  assign mine      = own_q && ex_valid;
  assign alu_fire  = ex_valid && !is_mem && state_q == BUS_IDLE;
  assign mem_start = ex_valid && is_mem && state_q == BUS_IDLE;

  // Memory op waits for its response, anything else for a free bus
  assign ex_busy = ex_valid && ((state_q == BUS_IDLE) ? is_mem : !(bus_rsp && own_q));

  always_ff @(posedge g_clk) begin
    if (rst) begin
      state_q     <= BUS_IDLE;
      cyc_q       <= 1'b0;
      own_q       <= 1'b0;
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= alu_fire || bus_done;
      if (mem_start) begin
        state_q <= BUS_ACCESS;
        cyc_q   <= 1'b1;
        own_q   <= 1'b1;
      end else if (bus_done) begin
        state_q <= BUS_IDLE;
        cyc_q   <= 1'b0;                  // Drop the cycle after ack/err
        own_q   <= 1'b0;
      end else begin
        own_q   <= own_q && ex_valid;     // Flushed op loses its result
      end
    end
  end

  always_ff @(posedge g_clk) begin
    if (mem_start) begin
      we_q  <= ex_data.uop == UOP_SW;
      adr_q <= alu_out;
      dat_q <= ex_data.opr_c;
    end
    if (alu_fire) begin
      res_q.rd    <= ex_data.rd;
      res_q.wdata <= alu_out;
      res_q.wen   <= |ex_data.rd;
      res_q.fault <= 1'b0;
    end else if (bus_done) begin
      res_q.rd    <= ex_data.rd;
      res_q.wdata <= dmem_rsp.dat;
      res_q.wen   <= mine && !dmem_rsp.err && !we_q && |ex_data.rd;
      res_q.fault <= mine && dmem_rsp.err;   // Error retires without write
    end
  end

  always_comb begin
    dmem_req.cyc = cyc_q;
    dmem_req.stb = cyc_q;
    dmem_req.we  = we_q;
    dmem_req.sel = '1;                     // Word access only
    dmem_req.adr = adr_q;
    dmem_req.dat = dat_q;
  end

  assign res_valid = res_valid_q;
  assign res_data  = res_q;

  a_stb_in_cyc: assert property (@(posedge g_clk) disable iff (rst)
    dmem_req.stb |-> dmem_req.cyc);

  // Request held until the slave answers
  a_adr_stable: assert property (@(posedge g_clk) disable iff (rst)
    dmem_req.cyc && !bus_rsp |=> dmem_req.cyc && $stable(dmem_req.adr));

endmodule
`default_nettype wire

//--- project.f
common/frv_pkg.sv
dispatch/frv_gprs.sv
dispatch/frv_pipeline_dispatch.sv
execute/frv_pipeline_execute.sv
design/frv_pipe_reg.sv
design/frv_pipeline_writeback.sv
design/frv_pipeline_back.sv
dv/tb_frv_pipeline_back.sv
